//--- files.f
+incdir+source
source/cpu_pkg.sv
source/regfile.sv
source/id_stage.sv
source/exe_stage.sv
source/mem_stage.sv
source/wb_stage.sv
source/cpu_core.sv
sim/cpu_core_sva.sv
sim/tb_cpu_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu_core -f files.f -o sim_cpu_core

# assertion failures are counted by the checker, so the run must not stop at the first one
out=$(./obj_dir/sim_cpu_core +verilator+error+limit+100 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

//--- sim/tb_cpu_core.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tb_cpu_core;

    localparam int num_insts  = 200;
    localparam int clk_period = 100;
    // 4 stages, 4 stall cycles and 2 idle cycles per instruction
    localparam int run_limit  = num_insts * 10 * clk_period + 200 * clk_period;

    logic                  clk;
    logic                  reset;
    logic                  inst_valid;
    logic [31:0]           inst;
    logic [`CPU_XLEN-1:0]  inst_pc;
    logic                  inst_allowin;
    logic [`CPU_XLEN-1:0]  debug_wb_pc;
    logic [3:0]            debug_wb_rf_wen;
    logic [4:0]            debug_wb_rf_wnum;
    logic [`CPU_XLEN-1:0]  debug_wb_rf_wdata;

    cpu_core i_dut (
        .clk, .reset, .inst_valid, .inst, .inst_pc, .inst_allowin,
        .debug_wb_pc, .debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    task automatic wait_edge();
        @(posedge clk);
        #10;
    endtask

    // registers 0 to 7 only so hazards come often
    function automatic logic [31:0] random_inst();
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
        op  = 6'h00;
        rs  = 5'($urandom_range(7));
        rt  = 5'($urandom_range(7));
        imm = 16'($urandom);
        case ($urandom_range(12))
            0: op = cpu_pkg::OP_ADD;
            1: op = cpu_pkg::OP_SUB;
            2: op = cpu_pkg::OP_AND;
            3: op = cpu_pkg::OP_OR;
            4: op = cpu_pkg::OP_XOR;
            5: op = cpu_pkg::OP_SLT;
            6: op = cpu_pkg::OP_ADDI;
            7: op = cpu_pkg::OP_LUI;
            8: op = cpu_pkg::OP_LW;
            9: op = cpu_pkg::OP_SW;
            10: op = 6'h10;
            11: op = 6'h00;
            default: op = 6'h3f;
        endcase
        if (op inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
                       cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_SLT}) begin
            imm[15:11] = 5'($urandom_range(7));
        end
        // base r0 with a word offset in the first 16 words
        if (op == cpu_pkg::OP_LW || op == cpu_pkg::OP_SW) begin
            rs  = 5'd0;
            imm = {10'd0, 4'($urandom_range(15)), 2'b00};
        end
        return {op, rs, rt, imm};
    endfunction

    task automatic offer(input logic [31:0] word, input logic [`CPU_XLEN-1:0] pc);
        logic taken;
        inst_valid = 1'b1;
        inst       = word;
        inst_pc    = pc;
        taken      = 1'b0;
        while (!taken) begin
            #5;
            taken = inst_allowin;
            wait_edge();
        end
        inst_valid = 1'b0;
    endtask

    initial begin : stimulus
        logic [`CPU_XLEN-1:0] pc;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        inst_pc    = '0;
        pc         = 32'h1c00_0000;
        void'($urandom(32'hbede));
        repeat (4) @(posedge clk);
        #10;
        reset = 1'b0;
        for (int n = 0; n < num_insts; n++) begin
            // long gap lets the pipeline drain fully
            if (n % 40 == 20) begin
                repeat (10) wait_edge();
            end
            while ($urandom_range(3) == 0) begin
                wait_edge();
            end
            offer(random_inst(), pc);
            pc = pc + 32'd4;
        end
        repeat (10) wait_edge();
        if (i_dut.i_sva.pending == 0 && i_dut.i_sva.err_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("[ERROR] time %0t: %0d expected traces never appeared", $time,
                     i_dut.i_sva.pending);
            $display("TEST FAILED");
            $fatal(1, "instructions were lost in the pipeline");
        end
    end

    always @(posedge clk) begin
        if (i_dut.i_sva.err_count != 0) begin
            $display("[ERROR] time %0t: checker assertion failed", $time);
            $display("TEST FAILED");
            $fatal(1, "run stopped by a failing checker assertion");
        end
    end

    initial begin : watchdog
        #(run_limit);
        $display("TEST FAILED");
        $fatal(1, "timeout, the instruction stream did not finish within %0d ns", run_limit);
    end

endmodule

//--- sim/cpu_core_sva.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_core_sva (
    input logic                  clk,
    input logic                  reset,
    input logic                  inst_valid,
    input logic [31:0]           inst,
    input logic [`CPU_XLEN-1:0]  inst_pc,
    input logic                  inst_allowin,
    input logic [`CPU_XLEN-1:0]  debug_wb_pc,
    input logic [3:0]            debug_wb_rf_wen,
    input logic [4:0]            debug_wb_rf_wnum,
    input logic [`CPU_XLEN-1:0]  debug_wb_rf_wdata
);

    // one expected write-back trace
    typedef struct packed {
        logic [4:0]            dest;
        logic [`CPU_XLEN-1:0]  value;
        logic [`CPU_XLEN-1:0]  pc;
    } trace_t;

    logic [`CPU_XLEN-1:0]  shadow_rf [`CPU_NREGS];
    logic [`CPU_XLEN-1:0]  shadow_mem [16];
    trace_t                exp_q [256];
    trace_t                exp_head;
    logic [7:0]            head;
    logic [7:0]            tail;
    int                    pending;
    int                    idle_cycles;
    logic                  started;
    logic                  accept;
    logic                  trace;
    logic [3:0]            quiet_pipe;
    logic [`CPU_XLEN-1:0]  quiet_pc [4];
    int                    err_count = 0;

    assign accept   = inst_valid && inst_allowin;
    assign trace    = debug_wb_rf_wen != 4'b0000;
    assign exp_head = exp_q[head];

    // architectural model stepped once per accepted instruction
    always @(posedge clk) begin : shadow_model
        logic [4:0]            rs;
        logic [4:0]            rt;
        logic [`CPU_XLEN-1:0]  a;
        logic [`CPU_XLEN-1:0]  b;
        logic [`CPU_XLEN-1:0]  imm;
        logic [`CPU_XLEN-1:0]  addr;
        logic                  writes;
        logic                  store;
        trace_t                entry;
        rs            = inst[25:21];
        rt            = inst[20:16];
        a             = shadow_rf[rs];
        b             = shadow_rf[rt];
        imm           = {{(`CPU_XLEN-16){inst[15]}}, inst[15:0]};
        addr          = a + imm;
        writes        = 1'b1;
        store         = inst[31:26] == cpu_pkg::OP_SW;
        entry.dest    = inst[15:11];
        entry.value   = '0;
        entry.pc      = inst_pc;
        case (inst[31:26])
            cpu_pkg::OP_ADD: entry.value = a + b;
            cpu_pkg::OP_SUB: entry.value = a - b;
            cpu_pkg::OP_AND: entry.value = a & b;
            cpu_pkg::OP_OR:  entry.value = a | b;
            cpu_pkg::OP_XOR: entry.value = a ^ b;
            cpu_pkg::OP_SLT: entry.value = {{(`CPU_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            cpu_pkg::OP_ADDI: begin
                entry.dest  = rt;
                entry.value = addr;
            end
            cpu_pkg::OP_LUI: begin
                entry.dest  = rt;
                entry.value = {inst[15:0], 16'h0000};
            end
            cpu_pkg::OP_LW: begin
                entry.dest  = rt;
                entry.value = shadow_mem[addr[5:2]];
            end
            // sw and unlisted encodings leave no trace
            default: writes = 1'b0;
        endcase
        if (reset) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                shadow_rf[i] <= '0;
            end
            for (int i = 0; i < 16; i++) begin
                shadow_mem[i] <= '0;
            end
            head        <= '0;
            tail        <= '0;
            pending     <= 0;
            idle_cycles <= 100;
            started     <= 1'b0;
            quiet_pipe  <= '0;
        end else begin
            if (accept) begin
                started <= 1'b1;
                if (writes) begin
                    exp_q[tail] <= entry;
                    tail        <= tail + 8'd1;
                    // r0 still traces but keeps reading zero
                    if (entry.dest != 5'd0) begin
                        shadow_rf[entry.dest] <= entry.value;
                    end
                end
                if (store) begin
                    shadow_mem[addr[5:2]] <= b;
                end
            end
            if (trace) begin
                head <= head + 8'd1;
            end
            pending     <= pending + ((accept && writes) ? 1 : 0) - (trace ? 1 : 0);
            quiet_pipe  <= {quiet_pipe[2:0], accept && writes && (idle_cycles >= 7)};
            quiet_pc[0] <= inst_pc;
            quiet_pc[1] <= quiet_pc[0];
            quiet_pc[2] <= quiet_pc[1];
            quiet_pc[3] <= quiet_pc[2];
            idle_cycles <= accept ? 0 : ((idle_cycles < 100) ? idle_cycles + 1 : idle_cycles);
        end
    end

    a_idle_after_reset: assert property (@(posedge clk) disable iff (reset)
        !started |-> (debug_wb_rf_wen == 4'b0000) && inst_allowin)
        else begin
            err_count++;
            $error("trace or back-pressure seen before the first instruction");
        end

    a_trace_expected: assert property (@(posedge clk) disable iff (reset)
        trace |-> pending > 0)
        else begin
            err_count++;
            $error("trace with no instruction outstanding");
        end

    a_trace_match: assert property (@(posedge clk) disable iff (reset)
        trace |-> (debug_wb_rf_wnum == exp_head.dest) && (debug_wb_rf_wdata == exp_head.value)
            && (debug_wb_pc == exp_head.pc))
        else begin
            err_count++;
            $error("trace differs from the expected write-back");
        end

    // empty pipeline means no stall can stretch the latency
    a_quiet_latency: assert property (@(posedge clk) disable iff (reset)
        quiet_pipe[3] |-> trace && (debug_wb_pc == quiet_pc[3]))
        else begin
            err_count++;
            $error("instruction did not trace four cycles after acceptance");
        end

endmodule

bind cpu_core cpu_core_sva i_sva (
    .clk               (clk),
    .reset             (reset),
    .inst_valid        (inst_valid),
    .inst              (inst),
    .inst_pc           (inst_pc),
    .inst_allowin      (inst_allowin),
    .debug_wb_pc       (debug_wb_pc),
    .debug_wb_rf_wen   (debug_wb_rf_wen),
    .debug_wb_rf_wnum  (debug_wb_rf_wnum),
    .debug_wb_rf_wdata (debug_wb_rf_wdata)
);

//--- source/cpu_core.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_core (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inst_valid,
    input  logic [31:0]            inst,
    input  logic [`CPU_XLEN-1:0]   inst_pc,
    output logic                   inst_allowin,
    output logic [`CPU_XLEN-1:0]   debug_wb_pc,
    output logic [3:0]             debug_wb_rf_wen,
    output logic [4:0]             debug_wb_rf_wnum,
    output logic [`CPU_XLEN-1:0]   debug_wb_rf_wdata
);

    logic                   es_allowin;
    logic                   ms_allowin;
    logic                   ws_allowin;
    logic                   ds_to_es_valid;
    logic                   es_to_ms_valid;
    logic                   ms_to_ws_valid;
    cpu_pkg::ds_to_es_t     ds_to_es_bus;
    cpu_pkg::es_to_ms_t     es_to_ms_bus;
    cpu_pkg::ms_to_ws_t     ms_to_ws_bus;
    cpu_pkg::ws_to_rf_t     ws_to_rf_bus;
    cpu_pkg::stage_dest_t   es_dest;
    cpu_pkg::stage_dest_t   ms_dest;
    cpu_pkg::stage_dest_t   ws_dest;
    logic [4:0]             rf_raddr1;
    logic [4:0]             rf_raddr2;
    logic [`CPU_XLEN-1:0]   rf_rdata1;
    logic [`CPU_XLEN-1:0]   rf_rdata2;

    id_stage i_id_stage (
        .clk, .reset, .inst_valid, .inst, .inst_pc, .inst_allowin,
        .es_allowin, .es_dest, .ms_dest, .ws_dest,
        .ds_to_es_valid, .ds_to_es_bus,
        .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2
    );

    exe_stage i_exe_stage (
        .clk, .reset, .ds_to_es_valid, .ds_to_es_bus, .es_allowin,
        .ms_allowin, .es_to_ms_valid, .es_to_ms_bus, .es_dest
    );

    mem_stage i_mem_stage (
        .clk, .reset, .es_to_ms_valid, .es_to_ms_bus, .ms_allowin,
        .ws_allowin, .ms_to_ws_valid, .ms_to_ws_bus, .ms_dest
    );

    wb_stage i_wb_stage (
        .clk, .reset, .ws_allowin, .ms_to_ws_valid, .ms_to_ws_bus,
        .ws_to_rf_bus, .ws_dest,
        .debug_wb_pc, .debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    regfile i_regfile (
        .clk, .reset, .ws_to_rf_bus,
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

endmodule

//--- source/wb_stage.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module wb_stage (
    input  logic                   clk,
    input  logic                   reset,
    output logic                   ws_allowin,
    input  logic                   ms_to_ws_valid,
    input  cpu_pkg::ms_to_ws_t     ms_to_ws_bus,
    output cpu_pkg::ws_to_rf_t     ws_to_rf_bus,
    output cpu_pkg::stage_dest_t   ws_dest,
    // trace port
    output logic [`CPU_XLEN-1:0]   debug_wb_pc,
    output logic [3:0]             debug_wb_rf_wen,
    output logic [4:0]             debug_wb_rf_wnum,
    output logic [`CPU_XLEN-1:0]   debug_wb_rf_wdata
);

    logic                  ws_valid;
    logic                  ws_ready_go;
    logic                  rf_we;
    cpu_pkg::ms_to_ws_t    ws_bus_r;

    assign ws_ready_go = 1'b1;
    assign ws_allowin  = !ws_valid || ws_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_bus_r <= ms_to_ws_bus;
        end
    end

    assign rf_we = ws_valid && ws_bus_r.rf_we;

    assign ws_to_rf_bus.we    = rf_we;
    assign ws_to_rf_bus.waddr = ws_bus_r.dest;
    assign ws_to_rf_bus.wdata = ws_bus_r.final_result;

    assign ws_dest.we   = rf_we;
    assign ws_dest.dest = ws_bus_r.dest;

    assign debug_wb_pc       = ws_bus_r.pc;
    assign debug_wb_rf_wen   = {4{rf_we}};
    assign debug_wb_rf_wnum  = ws_bus_r.dest;
    assign debug_wb_rf_wdata = ws_bus_r.final_result;

endmodule

//--- source/mem_stage.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module mem_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   es_to_ms_valid,
    input  cpu_pkg::es_to_ms_t     es_to_ms_bus,
    output logic                   ms_allowin,
    input  logic                   ws_allowin,
    output logic                   ms_to_ws_valid,
    output cpu_pkg::ms_to_ws_t     ms_to_ws_bus,
    output cpu_pkg::stage_dest_t   ms_dest
);

    localparam int dmem_aw = $clog2(`CPU_DMEM_WORDS);

    logic                  ms_valid;
    logic                  ms_ready_go;
    cpu_pkg::es_to_ms_t    ms_bus_r;
    logic [dmem_aw-1:0]    word_addr;
    logic [`CPU_XLEN-1:0]  load_data;
    logic [`CPU_XLEN-1:0]  dmem [`CPU_DMEM_WORDS];

    assign ms_ready_go    = 1'b1;
    assign ms_allowin     = !ms_valid || (ms_ready_go && ws_allowin);
    assign ms_to_ws_valid = ms_valid && ms_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_bus_r <= es_to_ms_bus;
        end
    end

    // word index from byte address bits 9:2
    assign word_addr = ms_bus_r.alu_result[dmem_aw+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ms_valid && ms_bus_r.is_store) begin
            dmem[word_addr] <= ms_bus_r.st_data;
        end
    end

    assign load_data = dmem[word_addr];

    assign ms_to_ws_bus.rf_we        = ms_bus_r.rf_we;
    assign ms_to_ws_bus.dest         = ms_bus_r.dest;
    assign ms_to_ws_bus.final_result = ms_bus_r.is_load ? load_data : ms_bus_r.alu_result;
    assign ms_to_ws_bus.pc           = ms_bus_r.pc;

    assign ms_dest.we   = ms_valid && ms_bus_r.rf_we;
    assign ms_dest.dest = ms_bus_r.dest;

endmodule

//--- source/exe_stage.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module exe_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ds_to_es_valid,
    input  cpu_pkg::ds_to_es_t     ds_to_es_bus,
    output logic                   es_allowin,
    input  logic                   ms_allowin,
    output logic                   es_to_ms_valid,
    output cpu_pkg::es_to_ms_t     es_to_ms_bus,
    output cpu_pkg::stage_dest_t   es_dest
);

    logic                  es_valid;
    logic                  es_ready_go;
    cpu_pkg::ds_to_es_t    es_bus_r;
    logic [`CPU_XLEN-1:0]  alu_result;

    assign es_ready_go    = 1'b1;
    assign es_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && es_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            es_bus_r <= ds_to_es_bus;
        end
    end

    // loads and stores use the add for their address
    always_comb begin
        case (es_bus_r.alu_op)
            cpu_pkg::ALU_SUB: alu_result = es_bus_r.src1 - es_bus_r.src2;
            cpu_pkg::ALU_AND: alu_result = es_bus_r.src1 & es_bus_r.src2;
            cpu_pkg::ALU_OR:  alu_result = es_bus_r.src1 | es_bus_r.src2;
            cpu_pkg::ALU_XOR: alu_result = es_bus_r.src1 ^ es_bus_r.src2;
            cpu_pkg::ALU_SLT: alu_result = {{(`CPU_XLEN-1){1'b0}},
                                            $signed(es_bus_r.src1) < $signed(es_bus_r.src2)};
            cpu_pkg::ALU_LUI: alu_result = es_bus_r.src2;
            default:          alu_result = es_bus_r.src1 + es_bus_r.src2;
        endcase
    end

    assign es_to_ms_bus.alu_result = alu_result;
    assign es_to_ms_bus.st_data    = es_bus_r.st_data;
    assign es_to_ms_bus.is_load    = es_bus_r.is_load;
    assign es_to_ms_bus.is_store   = es_bus_r.is_store;
    assign es_to_ms_bus.rf_we      = es_bus_r.rf_we;
    assign es_to_ms_bus.dest       = es_bus_r.dest;
    assign es_to_ms_bus.pc         = es_bus_r.pc;

    assign es_dest.we   = es_valid && es_bus_r.rf_we;
    assign es_dest.dest = es_bus_r.dest;

endmodule

//--- source/id_stage.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module id_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inst_valid,
    input  logic [31:0]            inst,
    input  logic [`CPU_XLEN-1:0]   inst_pc,
    output logic                   inst_allowin,
    input  logic                   es_allowin,
    input  cpu_pkg::stage_dest_t   es_dest,
    input  cpu_pkg::stage_dest_t   ms_dest,
    input  cpu_pkg::stage_dest_t   ws_dest,
    output logic                   ds_to_es_valid,
    output cpu_pkg::ds_to_es_t     ds_to_es_bus,
    output logic [4:0]             rf_raddr1,
    output logic [4:0]             rf_raddr2,
    input  logic [`CPU_XLEN-1:0]   rf_rdata1,
    input  logic [`CPU_XLEN-1:0]   rf_rdata2
);

    logic                  ds_valid;
    logic                  ds_ready_go;
    logic                  ds_allowin;
    logic [31:0]           ds_inst;
    logic [`CPU_XLEN-1:0]  ds_pc;

    cpu_pkg::opcode_e      opcode;
    cpu_pkg::alu_op_e      alu_op;
    logic [4:0]            rs;
    logic [4:0]            rt;
    logic [4:0]            rd;
    logic [4:0]            dest;
    logic [`CPU_XLEN-1:0]  imm_val;
    logic                  r_type;
    logic                  src2_is_imm;
    logic                  rf_we;
    logic                  is_load;
    logic                  is_store;
    logic                  use_rs;
    logic                  use_rt;
    logic                  hazard;

    function automatic logic dest_hit(cpu_pkg::stage_dest_t d, logic [4:0] r);
        return d.we && (d.dest == r);
    endfunction

    assign ds_ready_go    = !hazard;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign inst_allowin   = ds_allowin;
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid && ds_allowin) begin
            ds_inst <= inst;
            ds_pc   <= inst_pc;
        end
    end

    assign opcode = cpu_pkg::opcode_e'(ds_inst[31:26]);
    assign rs     = ds_inst[25:21];
    assign rt     = ds_inst[20:16];
    assign rd     = ds_inst[15:11];

    always_comb begin
        r_type      = 1'b0;
        alu_op      = cpu_pkg::ALU_ADD;
        src2_is_imm = 1'b0;
        rf_we       = 1'b0;
        is_load     = 1'b0;
        is_store    = 1'b0;
        use_rs      = 1'b0;
        use_rt      = 1'b0;
        dest        = rt;
        imm_val     = {{(`CPU_XLEN-16){ds_inst[15]}}, ds_inst[15:0]};
        case (opcode)
            cpu_pkg::OP_ADD: begin
                r_type = 1'b1;
                alu_op = cpu_pkg::ALU_ADD;
            end
            cpu_pkg::OP_SUB: begin
                r_type = 1'b1;
                alu_op = cpu_pkg::ALU_SUB;
            end
            cpu_pkg::OP_AND: begin
                r_type = 1'b1;
                alu_op = cpu_pkg::ALU_AND;
            end
            cpu_pkg::OP_OR: begin
                r_type = 1'b1;
                alu_op = cpu_pkg::ALU_OR;
            end
            cpu_pkg::OP_XOR: begin
                r_type = 1'b1;
                alu_op = cpu_pkg::ALU_XOR;
            end
            cpu_pkg::OP_SLT: begin
                r_type = 1'b1;
                alu_op = cpu_pkg::ALU_SLT;
            end
            cpu_pkg::OP_ADDI: begin
                src2_is_imm = 1'b1;
                rf_we       = 1'b1;
                use_rs      = 1'b1;
            end
            cpu_pkg::OP_LUI: begin
                alu_op      = cpu_pkg::ALU_LUI;
                src2_is_imm = 1'b1;
                rf_we       = 1'b1;
                imm_val     = {ds_inst[15:0], 16'h0000};
            end
            cpu_pkg::OP_LW: begin
                src2_is_imm = 1'b1;
                rf_we       = 1'b1;
                is_load     = 1'b1;
                use_rs      = 1'b1;
            end
            cpu_pkg::OP_SW: begin
                src2_is_imm = 1'b1;
                is_store    = 1'b1;
                use_rs      = 1'b1;
                use_rt      = 1'b1;
            end
            // unlisted encodings fall through as a nop
            default: begin
                rf_we = 1'b0;
            end
        endcase
        if (r_type) begin
            rf_we  = 1'b1;
            use_rs = 1'b1;
            use_rt = 1'b1;
            dest   = rd;
        end
    end

    // hold while an older in-flight instruction will write a source
    assign hazard = ds_valid && (
        (use_rs && (rs != 5'd0) &&
            (dest_hit(es_dest, rs) || dest_hit(ms_dest, rs) || dest_hit(ws_dest, rs))) ||
        (use_rt && (rt != 5'd0) &&
            (dest_hit(es_dest, rt) || dest_hit(ms_dest, rt) || dest_hit(ws_dest, rt))));

    assign rf_raddr1 = rs;
    assign rf_raddr2 = rt;

    assign ds_to_es_bus.alu_op   = alu_op;
    assign ds_to_es_bus.src1     = rf_rdata1;
    assign ds_to_es_bus.src2     = src2_is_imm ? imm_val : rf_rdata2;
    assign ds_to_es_bus.st_data  = rf_rdata2;
    assign ds_to_es_bus.is_load  = is_load;
    assign ds_to_es_bus.is_store = is_store;
    assign ds_to_es_bus.rf_we    = rf_we;
    assign ds_to_es_bus.dest     = dest;
    assign ds_to_es_bus.pc       = ds_pc;

endmodule

//--- source/regfile.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module regfile (
    input  logic                   clk,
    input  logic                   reset,
    input  cpu_pkg::ws_to_rf_t     ws_to_rf_bus,
    input  logic [4:0]             raddr1,
    input  logic [4:0]             raddr2,
    output logic [`CPU_XLEN-1:0]   rdata1,
    output logic [`CPU_XLEN-1:0]   rdata2
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ws_to_rf_bus.we && (ws_to_rf_bus.waddr != 5'd0)) begin
            regs[ws_to_rf_bus.waddr] <= ws_to_rf_bus.wdata;
        end
    end

    // register zero always reads zero
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

//--- source/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

    // instruction bits 31:26
    typedef enum logic [5:0] {
        OP_ADD  = 6'h01,
        OP_SUB  = 6'h02,
        OP_AND  = 6'h03,
        OP_OR   = 6'h04,
        OP_XOR  = 6'h05,
        OP_SLT  = 6'h06,
        OP_ADDI = 6'h08,
        OP_LUI  = 6'h0f,
        OP_LW   = 6'h23,
        OP_SW   = 6'h2b
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_LUI = 4'd6
    } alu_op_e;

    typedef struct packed {
        alu_op_e               alu_op;
        logic [`CPU_XLEN-1:0]  src1;
        logic [`CPU_XLEN-1:0]  src2;
        logic [`CPU_XLEN-1:0]  st_data;
        logic                  is_load;
        logic                  is_store;
        logic                  rf_we;
        logic [4:0]            dest;
        logic [`CPU_XLEN-1:0]  pc;
    } ds_to_es_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0]  alu_result;
        logic [`CPU_XLEN-1:0]  st_data;
        logic                  is_load;
        logic                  is_store;
        logic                  rf_we;
        logic [4:0]            dest;
        logic [`CPU_XLEN-1:0]  pc;
    } es_to_ms_t;

    // write enable, destination, result and pc
    typedef struct packed {
        logic                  rf_we;
        logic [4:0]            dest;
        logic [`CPU_XLEN-1:0]  final_result;
        logic [`CPU_XLEN-1:0]  pc;
    } ms_to_ws_t;

    typedef struct packed {
        logic                  we;
        logic [4:0]            waddr;
        logic [`CPU_XLEN-1:0]  wdata;
    } ws_to_rf_t;

    // we is already qualified by the stage valid bit
    typedef struct packed {
        logic                  we;
        logic [4:0]            dest;
    } stage_dest_t;

endpackage

//--- source/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data path and address width
`define CPU_XLEN 32

// general registers including register zero
`define CPU_NREGS 32

// data memory depth in words
`define CPU_DMEM_WORDS 256

`endif
